// File: vlog.f
+incdir+rtl
rtl/sram_pkg.sv
rtl/bank_if.sv
rtl/bank_dispatch.sv
rtl/sram_bank_ctrl.sv
rtl/read_return.sv
rtl/sram_subsys.sv
dv/tb_clk_gen.sv
dv/sram_model.sv
dv/sram_checker.sv
dv/sram_bank_props.sv
dv/tb_sram_subsys.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module tb_sram_subsys -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
else
    exit 1
fi

// File: dv/tb_sram_subsys.sv
`include "sram_params.svh"

module tb_sram_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TXN          = 2000;
    localparam int TIMEOUT_CYCLES = N_TXN + 50;
    localparam int N_HOT          = 64;

    logic                              clk;
    logic                              rst_n;
    logic                              read_req;
    logic                              write_req;
    logic [`HOST_AW-1:0]               address;
    logic [`SRAM_DW-1:0]               write_data;
    logic                              ready;
    logic [`SRAM_DW-1:0]               read_data;
    logic                              read_valid;
    logic [`N_BANKS-1:0][`SRAM_AW-1:0] sram_addr;
    logic [`N_BANKS-1:0]               sram_ce_n;
    logic [`N_BANKS-1:0]               sram_oe_n;
    logic [`N_BANKS-1:0]               sram_we_n;
    wire  [`N_BANKS-1:0][`SRAM_DW-1:0] sram_data;
    logic [`HOST_AW-1:0]               hot_addr [N_HOT];
    int                                cycles;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sram_subsys u_sram_subsys (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_req   (read_req),
        .write_req  (write_req),
        .address    (address),
        .write_data (write_data),
        .ready      (ready),
        .read_data  (read_data),
        .read_valid (read_valid),
        .sram_addr  (sram_addr),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n),
        .sram_data  (sram_data)
    );

    for (genvar i = 0; i < `N_BANKS; i++) begin : g_chip
        sram_model u_chip (
            .addr (sram_addr[i]),
            .ce_n (sram_ce_n[i]),
            .oe_n (sram_oe_n[i]),
            .we_n (sram_we_n[i]),
            .data (sram_data[i])
        );
    end

    sram_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_req   (read_req),
        .write_req  (write_req),
        .address    (address),
        .write_data (write_data),
        .ready      (ready),
        .read_data  (read_data),
        .read_valid (read_valid),
        .sram_addr  (sram_addr),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n),
        .sram_data  (sram_data)
    );

    // mostly hot words so reads land on written data
    function automatic logic [`HOST_AW-1:0] pick_address();
        if (($urandom % 100) < 85) begin
            return hot_addr[$urandom % N_HOT];
        end
        return `HOST_AW'($urandom);
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    initial begin
        cycles     = 0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        address    = '0;
        write_data = '0;
        void'($urandom(32'h21747562));
        for (int k = 0; k < N_HOT; k++) begin
            hot_addr[k] = {`BANK_BITS'(k), `SRAM_AW'($urandom)};   // spread over banks
        end
        wait (rst_n === 1'b1);
        for (int n = 0; n < N_TXN; n++) begin
            @(negedge clk);
            read_req   = ($urandom % 100) < 40;
            write_req  = ($urandom % 100) < 40;
            address    = pick_address();
            write_data = `SRAM_DW'($urandom);
        end
        @(negedge clk);
        read_req  = 1'b0;
        write_req = 1'b0;
        while (u_checker.outstanding != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("closing: %0d writes, %0d reads, %0d errors",
                 u_checker.n_writes, u_checker.n_reads, u_checker.err_count);
        if (u_checker.err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/sram_bank_props.sv
module sram_bank_props (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sram_pkg::bank_state_t state,
    input  logic                  ce_n,
    input  logic                  oe_n,
    input  logic                  we_n
);
    timeunit 1ns;
    timeprecision 100ps;

    a_oe_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(!oe_n && !we_n))
        else $error("oe_n and we_n low in the same cycle");

    a_ce_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (oe_n && we_n) |-> ce_n)
        else $error("ce_n low with neither oe_n nor we_n active");

    // every access lasts exactly one cycle
    a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (state != sram_pkg::ST_IDLE) |=> (state == sram_pkg::ST_IDLE))
        else $error("bank stayed out of idle for two cycles");

endmodule

bind sram_bank_ctrl sram_bank_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .state (state),
    .ce_n  (sram_ce_n),
    .oe_n  (sram_oe_n),
    .we_n  (sram_we_n)
);

// File: dv/sram_checker.sv
`include "sram_params.svh"

module sram_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              read_req,
    input  logic                              write_req,
    input  logic [`HOST_AW-1:0]               address,
    input  logic [`SRAM_DW-1:0]               write_data,
    input  logic                              ready,
    input  logic [`SRAM_DW-1:0]               read_data,
    input  logic                              read_valid,
    input  logic [`N_BANKS-1:0][`SRAM_AW-1:0] sram_addr,
    input  logic [`N_BANKS-1:0]               sram_ce_n,
    input  logic [`N_BANKS-1:0]               sram_oe_n,
    input  logic [`N_BANKS-1:0]               sram_we_n,
    input  wire  [`N_BANKS-1:0][`SRAM_DW-1:0] sram_data
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int READ_LAT = 3;   // accept edge to the edge that sets read_valid
    localparam int K_NONE   = 0;
    localparam int K_READ   = 1;
    localparam int K_WRITE  = 2;

    int err_count;
    int n_writes;
    int n_reads;
    int outstanding;
    int cyc;

    logic [`SRAM_DW-1:0] shadow [0:(1 << `HOST_AW)-1];
    logic [`SRAM_DW-1:0] exp_data [$];
    int                  exp_due [$];

    // what each bank should be doing in the current cycle
    int                  act_kind [`N_BANKS];
    logic [`SRAM_AW-1:0] act_addr [`N_BANKS];
    logic [`SRAM_DW-1:0] act_data [`N_BANKS];

    initial begin
        err_count   = 0;
        n_writes    = 0;
        n_reads     = 0;
        outstanding = 0;
        cyc         = 0;
        for (int i = 0; i < (1 << `HOST_AW); i++) begin
            shadow[i] = '0;   // unwritten words read as zero
        end
        for (int k = 0; k < `N_BANKS; k++) begin
            act_kind[k] = K_NONE;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
            err_count++;
        end
    endtask

    task automatic verify_pins(input int k);
        string sfx;
        sfx = $sformatf("[%0d]", k);
        if (act_kind[k] == K_NONE) begin
            compare_value({"sram_ce_n", sfx}, 32'(sram_ce_n[k]), 32'd1);
            compare_value({"sram_oe_n", sfx}, 32'(sram_oe_n[k]), 32'd1);
            compare_value({"sram_we_n", sfx}, 32'(sram_we_n[k]), 32'd1);
        end else begin
            compare_value({"sram_ce_n", sfx}, 32'(sram_ce_n[k]), 32'd0);
            compare_value({"sram_oe_n", sfx}, 32'(sram_oe_n[k]),
                          (act_kind[k] == K_READ) ? 32'd0 : 32'd1);
            compare_value({"sram_we_n", sfx}, 32'(sram_we_n[k]),
                          (act_kind[k] == K_WRITE) ? 32'd0 : 32'd1);
            compare_value({"sram_addr", sfx}, 32'(sram_addr[k]), 32'(act_addr[k]));
            if (act_kind[k] == K_WRITE) begin
                compare_value({"sram_data", sfx}, 32'(sram_data[k]), 32'(act_data[k]));
            end
        end
    endtask

    // values sampled here were registered at the previous edge
    task automatic match_read_return();
        if (exp_due.size() > 0 && exp_due[0] == cyc - 1) begin
            if (read_valid !== 1'b1) begin
                $display("read return due at cycle %0d never arrived", exp_due[0]);
                err_count++;
            end else begin
                compare_value("read_data", 32'(read_data), 32'(exp_data[0]));
            end
            void'(exp_data.pop_front());
            void'(exp_due.pop_front());
        end else if (read_valid !== 1'b0) begin
            $display("read_valid raised at cycle %0d with no read due", cyc - 1);
            err_count++;
        end
    endtask

    always @(posedge clk) begin : l_sample
        logic [`BANK_BITS-1:0] sel;
        logic                  exp_ready;
        if (rst_n) begin
            cyc++;
            if (cyc == 1) begin
                compare_value("read_data", 32'(read_data), 32'd0);   // reset value
            end
            for (int k = 0; k < `N_BANKS; k++) begin
                verify_pins(k);
            end
            match_read_return();
            sel       = address[`HOST_AW-1 -: `BANK_BITS];
            exp_ready = (act_kind[sel] == K_NONE);
            compare_value("ready", 32'(ready), 32'(exp_ready));
            for (int k = 0; k < `N_BANKS; k++) begin
                act_kind[k] = K_NONE;
            end
            if (exp_ready && write_req) begin   // write wins over read
                shadow[address] = write_data;
                act_kind[sel]   = K_WRITE;
                act_addr[sel]   = address[`SRAM_AW-1:0];
                act_data[sel]   = write_data;
                n_writes++;
            end else if (exp_ready && read_req) begin
                exp_data.push_back(shadow[address]);
                exp_due.push_back(cyc + READ_LAT);
                act_kind[sel] = K_READ;
                act_addr[sel] = address[`SRAM_AW-1:0];
                n_reads++;
            end
            outstanding = exp_data.size();
        end
    end

endmodule

// File: dv/sram_model.sv
`include "sram_params.svh"

module sram_model (
    input  logic [`SRAM_AW-1:0] addr,
    input  logic                ce_n,
    input  logic                oe_n,
    input  logic                we_n,
    inout  wire  [`SRAM_DW-1:0] data
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETTLE_NS = 10;   // pins settle well inside the write pulse

    logic [`SRAM_DW-1:0] mem [0:(1 << `SRAM_AW)-1];
    logic                armed;
    logic [`SRAM_AW-1:0] wr_addr;
    logic [`SRAM_DW-1:0] wr_data;

    initial begin
        armed = 1'b0;
        for (int i = 0; i < (1 << `SRAM_AW); i++) begin
            mem[i] = '0;
        end
    end

    // output enable drives the bus, otherwise released
    assign data = (!ce_n && !oe_n) ? mem[addr] : 'z;

    // capture address and data during the pulse
    always @(negedge we_n) begin
        #SETTLE_NS;
        armed   = !ce_n && !we_n;
        wr_addr = addr;
        wr_data = data;
    end

    always @(posedge we_n) begin
        if (armed) begin
            mem[wr_addr] = wr_data;   // commit at end of write
        end
        armed = 1'b0;
    end

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;   // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // hold reset over three rising edges, release away from them
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: rtl/sram_subsys.sv
`include "sram_params.svh"

module sram_subsys (
    input  logic                              clk,
    input  logic                              rst_n,

    // host side
    input  logic                              read_req,
    input  logic                              write_req,
    input  logic [`HOST_AW-1:0]               address,
    input  logic [`SRAM_DW-1:0]               write_data,
    output logic                              ready,
    output logic [`SRAM_DW-1:0]               read_data,
    output logic                              read_valid,

    // one SRAM chip per bank
    output logic [`N_BANKS-1:0][`SRAM_AW-1:0] sram_addr,
    output logic [`N_BANKS-1:0]               sram_ce_n,
    output logic [`N_BANKS-1:0]               sram_oe_n,
    output logic [`N_BANKS-1:0]               sram_we_n,
    inout  wire  [`N_BANKS-1:0][`SRAM_DW-1:0] sram_data
);

    bank_if banks [`N_BANKS] ();

    bank_dispatch u_dispatch (
        .read_req   (read_req),
        .write_req  (write_req),
        .address    (address),
        .write_data (write_data),
        .ready      (ready),
        .banks      (banks)
    );

    for (genvar i = 0; i < `N_BANKS; i++) begin : g_bank
        sram_bank_ctrl u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .bus       (banks[i]),
            .sram_addr (sram_addr[i]),
            .sram_ce_n (sram_ce_n[i]),
            .sram_oe_n (sram_oe_n[i]),
            .sram_we_n (sram_we_n[i]),
            .sram_data (sram_data[i])
        );
    end

    // in-order return, banks never collide on rvalid
    read_return u_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .banks      (banks),
        .read_data  (read_data),
        .read_valid (read_valid)
    );

endmodule

// File: rtl/read_return.sv
`include "sram_params.svh"

module read_return (
    input  logic                clk,
    input  logic                rst_n,
    bank_if.drain               banks [`N_BANKS],
    output logic [`SRAM_DW-1:0] read_data,
    output logic                read_valid
);

    logic [`SRAM_DW-1:0] bank_rdata [`N_BANKS];
    logic [`N_BANKS-1:0] bank_rvalid;
    logic [`SRAM_DW-1:0] sel_data;

    for (genvar i = 0; i < `N_BANKS; i++) begin : g_gather
        assign bank_rdata[i]  = banks[i].rdata;
        assign bank_rvalid[i] = banks[i].rvalid;
    end

    // fixed latency keeps rvalid one-hot, so a plain OR is enough
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < `N_BANKS; i++) begin
            sel_data = sel_data | (bank_rdata[i] & {`SRAM_DW{bank_rvalid[i]}});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data  <= '0;
            read_valid <= 1'b0;
        end else begin
            read_valid <= |bank_rvalid;
            if (|bank_rvalid) begin
                read_data <= sel_data;   // held between returns
            end
        end
    end

endmodule

// File: rtl/sram_bank_ctrl.sv
`include "sram_params.svh"

module sram_bank_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    bank_if.bank                bus,
    output logic [`SRAM_AW-1:0] sram_addr,
    output logic                sram_ce_n,
    output logic                sram_oe_n,
    output logic                sram_we_n,
    inout  wire  [`SRAM_DW-1:0] sram_data
);

    sram_pkg::bank_state_t state;
    sram_pkg::bank_state_t next_state;

    logic [`SRAM_AW-1:0] addr_q;
    logic [`SRAM_DW-1:0] wdata_q;
    logic [`SRAM_DW-1:0] rd_q;       // bus sample at end of the read cycle
    logic                rd_pend;    // rd_q holds fresh data
    logic [`SRAM_DW-1:0] rdata_q;
    logic                rvalid_q;

    always_comb begin
        next_state = state;
        case (state)
            sram_pkg::ST_IDLE: begin
                if (bus.op == sram_pkg::OP_WRITE) begin
                    next_state = sram_pkg::ST_WRITE;
                end else if (bus.op == sram_pkg::OP_READ) begin
                    next_state = sram_pkg::ST_READ;
                end
            end
            sram_pkg::ST_READ:  next_state = sram_pkg::ST_IDLE;
            sram_pkg::ST_WRITE: next_state = sram_pkg::ST_IDLE;
            default:            next_state = sram_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= sram_pkg::ST_IDLE;
            rd_pend  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            state    <= next_state;
            rd_pend  <= (state == sram_pkg::ST_READ);
            rvalid_q <= rd_pend;
        end
    end

    // capture the request as the bank leaves idle
    always_ff @(posedge clk) begin
        if (state == sram_pkg::ST_IDLE && bus.op != sram_pkg::OP_NONE) begin
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == sram_pkg::ST_READ) begin
            rd_q <= sram_data;   // oe_n has been low the whole cycle
        end
        if (rd_pend) begin
            rdata_q <= rd_q;
        end
    end

    // chip pins, all high while idle
    assign sram_ce_n = (state == sram_pkg::ST_IDLE);
    assign sram_oe_n = (state != sram_pkg::ST_READ);
    assign sram_we_n = (state != sram_pkg::ST_WRITE);
    assign sram_addr = addr_q;

    // drive the bus only during a write
    assign sram_data = (state == sram_pkg::ST_WRITE) ? wdata_q : 'z;

    assign bus.idle   = (state == sram_pkg::ST_IDLE);
    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;

endmodule

// File: rtl/bank_dispatch.sv
`include "sram_params.svh"

module bank_dispatch (
    input  logic                read_req,
    input  logic                write_req,
    input  logic [`HOST_AW-1:0] address,
    input  logic [`SRAM_DW-1:0] write_data,
    output logic                ready,
    bank_if.disp                banks [`N_BANKS]
);

    logic [`BANK_BITS-1:0] bank_sel;
    logic [`SRAM_AW-1:0]   chip_addr;
    logic [`N_BANKS-1:0]   idle_vec;
    sram_pkg::bank_op_t    req_op;

    assign bank_sel  = address[`HOST_AW-1 -: `BANK_BITS];
    assign chip_addr = address[`SRAM_AW-1:0];

    // only the addressed bank decides ready
    assign ready = idle_vec[bank_sel];

    // write wins when both strobes are up
    always_comb begin
        req_op = sram_pkg::OP_NONE;
        if (ready) begin
            if (write_req) begin
                req_op = sram_pkg::OP_WRITE;
            end else if (read_req) begin
                req_op = sram_pkg::OP_READ;
            end
        end
    end

    for (genvar i = 0; i < `N_BANKS; i++) begin : g_fan
        assign idle_vec[i]    = banks[i].idle;
        assign banks[i].addr  = chip_addr;     // shared, only op is per bank
        assign banks[i].wdata = write_data;
        assign banks[i].op    = (bank_sel == `BANK_BITS'(i)) ? req_op : sram_pkg::OP_NONE;
    end

endmodule

// File: rtl/bank_if.sv
`include "sram_params.svh"

interface bank_if;

    // request side, from dispatch
    sram_pkg::bank_op_t       op;
    logic [`SRAM_AW-1:0]      addr;    // chip address, bank bits stripped
    logic [`SRAM_DW-1:0]      wdata;

    logic                     idle;    // bank can take a request this cycle

    // read return, one-cycle pulse
    logic [`SRAM_DW-1:0]      rdata;
    logic                     rvalid;

    modport disp (
        output op,
        output addr,
        output wdata,
        input  idle
    );

    modport bank (
        input  op,
        input  addr,
        input  wdata,
        output idle,
        output rdata,
        output rvalid
    );

    modport drain (
        input  rdata,
        input  rvalid
    );

endinterface

// File: rtl/sram_pkg.sv
package sram_pkg;

    // request from dispatch to one bank
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } bank_op_t;

    // per-bank access FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,   // oe_n low for one cycle
        ST_WRITE = 2'd2    // we_n low, bus driven for one cycle
    } bank_state_t;

endpackage

// File: rtl/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// chip address width, one async SRAM per bank
`define SRAM_AW 15

// word width on the chip data pins and at the host
`define SRAM_DW 16

// bank count and the matching select width
`define N_BANKS 4
`define BANK_BITS 2

// host word address: bank select on top of the chip address
`define HOST_AW (`SRAM_AW + `BANK_BITS)

`endif
